/* rtp_ctrl.f */
source/rtp_pkg.sv
source/rtp_i2c_master.sv
source/rtp_scan_sequencer.sv
source/rtp_point_assembler.sv
source/rtp_ctrl.sv
test/ns2009_model.sv
test/rtp_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rtp_ctrl testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rtp_ctrl_tb -f rtp_ctrl.f \
    -o rtp_ctrl_sim > sim.log 2>&1 \
    && ./obj_dir/rtp_ctrl_sim >> sim.log 2>&1 \
    || echo "simulation build or run failed" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* test/rtp_ctrl_tb.sv */
// ----------------------------------------------------------
// testbench for the NS2009 scan controller
// runs touched, untouched and NACK scans against the bus
// model and checks results, handshake and bus idle times
// ----------------------------------------------------------

module rtp_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_div     = 4;
    localparam int scan_ns     = 6 * 29 * 4 * clk_div * 10;  // six transactions of bus time
    localparam int watchdog_ns = 10 * scan_ns + 20000;

    logic        clk;
    logic        rst_n;
    logic        scan_req;
    logic        scan_ack;
    logic [11:0] x;
    logic [11:0] y;
    logic [11:0] z1;
    logic        touched;
    logic        bus_error;
    logic        scl_drive_low;
    logic        sda_drive_low;
    logic        scl_in;
    logic        sda_in;
    logic [11:0] x_val;
    logic [11:0] y_val;
    logic [11:0] z1_val;
    logic        ack_enable;
    logic        proto_err;
    logic        host_owns_bus;   // between scan_ack rising and the next request
    logic [15:0] lfsr;
    logic [11:0] rx;
    logic [11:0] ry;
    logic [11:0] rz;

    rtp_ctrl #(.clk_div(clk_div), .touch_threshold(12'd100)) i_rtp_ctrl (
        .clk(clk), .rst_n(rst_n), .scan_req(scan_req), .scan_ack(scan_ack),
        .x(x), .y(y), .z1(z1), .touched(touched), .bus_error(bus_error),
        .scl_drive_low(scl_drive_low), .sda_drive_low(sda_drive_low),
        .scl_in(scl_in), .sda_in(sda_in)
    );

    ns2009_model i_ns2009_model (
        .clk(clk), .rst_n(rst_n), .scl_drive_low(scl_drive_low),
        .sda_drive_low(sda_drive_low), .x_val(x_val), .y_val(y_val), .z1_val(z1_val),
        .ack_enable(ack_enable), .scl(scl_in), .sda(sda_in), .proto_err(proto_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_value(input string name, input logic [11:0] expected,
                              input logic [11:0] actual);
        $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%0t ns: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int n, output logic [11:0] v);
        v = 12'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[10:0], lfsr[0]};                // one step per bit taken
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n)        host_owns_bus <= 1'b1;
        else if (scan_ack) host_owns_bus <= 1'b1;
        else if (scan_req) host_owns_bus <= 1'b0;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!proto_err) else fail_plain("bus model reported a protocol error");
            if (host_owns_bus) begin                  // bus must stay quiet
                assert (!scl_drive_low) else fail_value("scl_drive_low", 12'd0, 12'(scl_drive_low));
                assert (!sda_drive_low) else fail_value("sda_drive_low", 12'd0, 12'(sda_drive_low));
            end
        end
    end

    // ack held as long as the host holds the request
    assert property (@(posedge clk) disable iff (!rst_n) (scan_ack && scan_req) |=> scan_ack)
        else fail_plain("scan_ack fell while scan_req was still high");

    task automatic check_result(input logic [11:0] ex, ey, ez, input logic et, eb);
        assert (x === ex) else fail_value("x", ex, x);
        assert (y === ey) else fail_value("y", ey, y);
        assert (z1 === ez) else fail_value("z1", ez, z1);
        assert (touched === et) else fail_value("touched", 12'(et), 12'(touched));
        assert (bus_error === eb) else fail_value("bus_error", 12'(eb), 12'(bus_error));
    endtask

    task automatic run_scan(input logic [11:0] xv, yv, zv, input logic ack_en);
        logic [11:0] ex;
        logic [11:0] ey;
        logic [11:0] ez;
        logic        et;
        logic [11:0] hold;
        ex = ack_en ? xv : 12'd0;                     // unread samples are zero
        ey = ack_en ? yv : 12'd0;
        ez = ack_en ? zv : 12'd0;
        et = ack_en && (zv > 12'd100);
        draw(4, hold);
        @(negedge clk);
        x_val      = xv;
        y_val      = yv;
        z1_val     = zv;
        ack_enable = ack_en;
        scan_req   = 1'b1;
        while (!scan_ack) @(negedge clk);
        check_result(ex, ey, ez, et, !ack_en);
        repeat (int'(hold) + 3) @(negedge clk);       // host stalls the result
        assert (scan_ack) else fail_value("scan_ack", 12'd1, 12'(scan_ack));
        check_result(ex, ey, ez, et, !ack_en);
        scan_req = 1'b0;
        while (scan_ack) @(negedge clk);
        assert (!scl_drive_low && !sda_drive_low) else fail_plain("bus not released after scan");
        repeat (5) @(negedge clk);
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: scans did not finish in %0d ns", watchdog_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        rst_n      = 1'b0;
        scan_req   = 1'b0;
        x_val      = 12'd0;
        y_val      = 12'd0;
        z1_val     = 12'd0;
        ack_enable = 1'b1;
        lfsr       = 16'd44554;
        repeat (2) @(posedge clk);                    // two reset cycles
        @(negedge clk);
        rst_n = 1'b1;
        repeat (20) begin                             // idle after reset
            @(negedge clk);
            assert (!scan_ack) else fail_value("scan_ack", 12'd0, 12'(scan_ack));
        end
        for (int i = 0; i < 2; i++) begin             // touched
            draw(12, rx);
            draw(12, ry);
            draw(10, rz);
            run_scan(rx, ry, rz + 12'd101, 1'b1);
        end
        draw(12, rx);
        draw(12, ry);
        run_scan(rx, ry, 12'd100, 1'b1);              // exactly at threshold
        draw(12, rx);
        draw(12, ry);
        draw(6, rz);
        run_scan(rx, ry, rz, 1'b1);
        run_scan(12'hABC, 12'h123, 12'h456, 1'b0);    // no acknowledge
        draw(12, rx);
        draw(12, ry);
        run_scan(rx, ry, 12'hFFF, 1'b1);              // recovery after the error
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* test/ns2009_model.sv */
// ----------------------------------------------------------
// behavioral NS2009 slave on a wired-AND I2C bus
// answers command writes and two byte sample reads, checks
// the master's protocol and raises proto_err on a fault
// ----------------------------------------------------------

module ns2009_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        scl_drive_low,   // from the master
    input  logic        sda_drive_low,
    input  logic [11:0] x_val,
    input  logic [11:0] y_val,
    input  logic [11:0] z1_val,
    input  logic        ack_enable,      // 0 = never acknowledge
    output logic        scl,
    output logic        sda,
    output logic        proto_err
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        slave_low;
    logic        scl_q;
    logic        sda_q;
    logic        rw;
    logic        have_cmd;               // a command write came before the read
    logic [3:0]  bit_cnt;                // rising scl edges in this byte, 8 = ack
    logic [1:0]  byte_idx;               // 0 address, then data bytes
    logic [1:0]  cmd_idx;                // position in the x, y, z1 order
    logic [7:0]  shift;
    logic [7:0]  last_cmd;
    logic [7:0]  rx_byte;
    logic [7:0]  exp_cmd;
    logic [15:0] tx_word;
    logic [3:0]  tx_bit;

    assign scl     = !scl_drive_low;                  // pull-up, nobody stretches
    assign sda     = !(sda_drive_low || slave_low);
    assign rx_byte = {shift[6:0], sda};
    assign tx_bit  = ((byte_idx == 2'd1) ? 4'd15 : 4'd7) - bit_cnt;

    always_comb begin
        case (last_cmd)
            rtp_pkg::cmd_read_x: tx_word = {x_val, 4'h0};
            rtp_pkg::cmd_read_y: tx_word = {y_val, 4'h0};
            default:             tx_word = {z1_val, 4'h0};
        endcase
        case (cmd_idx)
            2'd0:    exp_cmd = rtp_pkg::cmd_read_x;
            2'd1:    exp_cmd = rtp_pkg::cmd_read_y;
            default: exp_cmd = rtp_pkg::cmd_read_z1;
        endcase
    end

    task protocol_fault(input string what);
        $display("protocol error at %0t ns: %s", $time, what);
        proto_err <= 1'b1;                            // sticky
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            slave_low <= 1'b0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            rw        <= 1'b0;
            have_cmd  <= 1'b0;
            bit_cnt   <= 4'd0;
            byte_idx  <= 2'd0;
            cmd_idx   <= 2'd0;
            shift     <= 8'h00;
            last_cmd  <= rtp_pkg::cmd_read_x;
            proto_err <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && (sda != sda_q)) begin      // start or stop
                // stop follows the single scl rise of its own bit
                if (sda ? (bit_cnt != 4'd1) : (bit_cnt != 4'd0))
                    protocol_fault("SDA changed while SCL high inside a byte");
                bit_cnt   <= 4'd0;
                byte_idx  <= 2'd0;
                slave_low <= 1'b0;
            end else if (scl && !scl_q) begin              // rising scl, sample
                if (bit_cnt == 4'd8) begin
                    if (rw && (byte_idx == 2'd1) && sda)
                        protocol_fault("master did not ACK the first read byte");
                    if (rw && (byte_idx == 2'd2) && !sda)
                        protocol_fault("master ACKed the last read byte");
                    bit_cnt  <= 4'd0;
                    byte_idx <= byte_idx + 2'd1;
                end else begin
                    shift   <= rx_byte;
                    bit_cnt <= bit_cnt + 4'd1;
                    if ((bit_cnt == 4'd7) && (byte_idx == 2'd0)) begin
                        if (rx_byte[7:1] != rtp_pkg::dev_addr)
                            protocol_fault("address byte is not 0x90 or 0x91");
                        rw <= rx_byte[0];
                        if (rx_byte[0]) begin
                            if (!have_cmd) protocol_fault("read without a command write");
                            have_cmd <= 1'b0;
                        end
                    end
                    if ((bit_cnt == 4'd7) && (byte_idx == 2'd1) && !rw) begin
                        if (rx_byte != exp_cmd) protocol_fault("command out of x, y, z1 order");
                        last_cmd <= rx_byte;
                        have_cmd <= 1'b1;
                        cmd_idx  <= (cmd_idx == 2'd2) ? 2'd0 : cmd_idx + 2'd1;
                    end
                end
            end else if (!scl && scl_q) begin              // falling scl, drive
                if (bit_cnt == 4'd8)
                    slave_low <= ack_enable && !(rw && (byte_idx != 2'd0));
                else if (rw && (byte_idx == 2'd1 || byte_idx == 2'd2))
                    slave_low <= ~tx_word[tx_bit];         // msb first
                else
                    slave_low <= 1'b0;
            end
        end
    end

endmodule

/* source/rtp_ctrl.sv */
// ----------------------------------------------------------
// NS2009 resistive touch scan controller, top level
// host four phase scan handshake in, x, y, z1 and flags out
// bus pads are split into drive low outputs and inputs
// ----------------------------------------------------------

module rtp_ctrl #(
    parameter int                           clk_div         = 62,     // 25 MHz / 400 kHz quarters
    parameter logic [rtp_pkg::sample_w-1:0] touch_threshold = 12'd100
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scan_req,
    output logic                         scan_ack,
    output logic [rtp_pkg::sample_w-1:0] x,
    output logic [rtp_pkg::sample_w-1:0] y,
    output logic [rtp_pkg::sample_w-1:0] z1,
    output logic                         touched,
    output logic                         bus_error,
    output logic                         scl_drive_low,
    output logic                         sda_drive_low,
    input  logic                         scl_in,
    input  logic                         sda_in
);

    logic                         xfer_req;
    logic                         xfer_rd;
    logic [7:0]                   xfer_cmd;
    logic                         xfer_ack;
    logic [rtp_pkg::sample_w-1:0] xfer_sample;
    logic                         xfer_nack;
    logic                         result_valid;
    rtp_pkg::axis_e               result_axis;
    logic                         scan_done;
    logic                         scan_err;

    rtp_scan_sequencer i_rtp_scan_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .scan_req     (scan_req),
        .scan_ack     (scan_ack),
        .xfer_ack     (xfer_ack),
        .xfer_nack    (xfer_nack),
        .xfer_req     (xfer_req),
        .xfer_rd      (xfer_rd),
        .xfer_cmd     (xfer_cmd),
        .result_valid (result_valid),
        .result_axis  (result_axis),
        .scan_done    (scan_done),
        .scan_err     (scan_err)
    );

    rtp_i2c_master #(
        .clk_div (clk_div)
    ) i_rtp_i2c_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .xfer_req      (xfer_req),
        .xfer_rd       (xfer_rd),
        .xfer_cmd      (xfer_cmd),
        .xfer_ack      (xfer_ack),
        .xfer_sample   (xfer_sample),
        .xfer_nack     (xfer_nack),
        .scl_drive_low (scl_drive_low),
        .sda_drive_low (sda_drive_low),
        .scl_in        (scl_in),
        .sda_in        (sda_in)
    );

    rtp_point_assembler #(
        .touch_threshold (touch_threshold)
    ) i_rtp_point_assembler (
        .clk          (clk),
        .rst_n        (rst_n),
        .scan_req     (scan_req),
        .result_valid (result_valid),
        .result_axis  (result_axis),
        .xfer_sample  (xfer_sample),
        .scan_done    (scan_done),
        .scan_err     (scan_err),
        .scan_ack     (scan_ack),
        .x            (x),
        .y            (y),
        .z1           (z1),
        .touched      (touched),
        .bus_error    (bus_error)
    );

endmodule

/* source/rtp_point_assembler.sv */
// ----------------------------------------------------------
// collects the x, y and z1 samples of one scan, decides the
// touched flag and holds the result for the host handshake
// ----------------------------------------------------------

module rtp_point_assembler #(
    parameter logic [rtp_pkg::sample_w-1:0] touch_threshold = 12'd100
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scan_req,
    input  logic                         result_valid,
    input  rtp_pkg::axis_e               result_axis,
    input  logic [rtp_pkg::sample_w-1:0] xfer_sample,
    input  logic                         scan_done,
    input  logic                         scan_err,
    output logic                         scan_ack,
    output logic [rtp_pkg::sample_w-1:0] x,
    output logic [rtp_pkg::sample_w-1:0] y,
    output logic [rtp_pkg::sample_w-1:0] z1,
    output logic                         touched,
    output logic                         bus_error
);

    logic scanning;
    logic scan_start;

    assign scan_start = scan_req && !scan_ack && !scanning;   // same condition as sequencer

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scanning  <= 1'b0;
            scan_ack  <= 1'b0;
            touched   <= 1'b0;
            bus_error <= 1'b0;
        end else begin
            if (scan_start) begin
                scanning  <= 1'b1;
                touched   <= 1'b0;
                bus_error <= 1'b0;
            end
            if (scan_done) begin
                scanning  <= 1'b0;
                touched   <= (z1 > touch_threshold) && !scan_err;
                bus_error <= scan_err;
                scan_ack  <= 1'b1;                             // results stable from here
            end else if (scan_ack && !scan_req) begin
                scan_ack <= 1'b0;
            end
        end
    end

    // samples not read in an aborted scan stay at zero
    always_ff @(posedge clk) begin
        if (scan_start) begin
            x  <= '0;
            y  <= '0;
            z1 <= '0;
        end else if (result_valid) begin
            case (result_axis)
                rtp_pkg::axis_x: x  <= xfer_sample;
                rtp_pkg::axis_y: y  <= xfer_sample;
                default:         z1 <= xfer_sample;
            endcase
        end
    end

endmodule

/* source/rtp_scan_sequencer.sv */
// ----------------------------------------------------------
// scan sequencer for the NS2009 controller
// on a host request it runs a command write and a sample read
// for x, y and z1 in turn through the I2C engine handshake
// ----------------------------------------------------------

module rtp_scan_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scan_req,
    input  logic                scan_ack,
    input  logic                xfer_ack,
    input  logic                xfer_nack,
    output logic                xfer_req,
    output logic                xfer_rd,
    output logic [7:0]          xfer_cmd,
    output logic                result_valid,   // sample on xfer_sample this cycle
    output rtp_pkg::axis_e      result_axis,
    output logic                scan_done,
    output logic                scan_err
);

    typedef enum logic [2:0] {
        s_idle,
        s_write,        // command write outstanding
        s_write_rel,    // wait for xfer_ack to drop
        s_read,         // sample read outstanding
        s_read_rel,
        s_host          // wait for the host ack to rise
    } seq_e;

    seq_e           state;
    rtp_pkg::axis_e axis;

    assign xfer_req     = (state == s_write) || (state == s_read);
    assign xfer_rd      = (state == s_read);
    assign result_valid = (state == s_read) && xfer_ack && !xfer_nack;
    assign result_axis  = axis;

    always_comb begin
        case (axis)
            rtp_pkg::axis_x: xfer_cmd = rtp_pkg::cmd_read_x;
            rtp_pkg::axis_y: xfer_cmd = rtp_pkg::cmd_read_y;
            default:         xfer_cmd = rtp_pkg::cmd_read_z1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= s_idle;
            axis      <= rtp_pkg::axis_x;
            scan_done <= 1'b0;
            scan_err  <= 1'b0;
        end else begin
            scan_done <= 1'b0;                                  // one cycle pulses
            scan_err  <= 1'b0;
            case (state)
                s_idle: begin
                    if (scan_req && !scan_ack) begin
                        axis  <= rtp_pkg::axis_x;
                        state <= s_write;
                    end
                end
                s_write: begin
                    if (xfer_ack) begin
                        if (xfer_nack) begin                    // abort the scan
                            scan_done <= 1'b1;
                            scan_err  <= 1'b1;
                            state     <= s_host;
                        end else begin
                            state <= s_write_rel;
                        end
                    end
                end
                s_write_rel: begin
                    if (!xfer_ack) state <= s_read;
                end
                s_read: begin
                    if (xfer_ack) begin
                        if (xfer_nack || (axis == rtp_pkg::axis_z1)) begin
                            scan_done <= 1'b1;
                            scan_err  <= xfer_nack;
                            state     <= s_host;
                        end else begin
                            state <= s_read_rel;
                        end
                    end
                end
                s_read_rel: begin
                    if (!xfer_ack) begin
                        axis  <= (axis == rtp_pkg::axis_x) ? rtp_pkg::axis_y : rtp_pkg::axis_z1;
                        state <= s_write;
                    end
                end
                default: begin
                    if (!xfer_ack && scan_ack) state <= s_idle;   // result now with host
                end
            endcase
        end
    end

endmodule

/* source/rtp_i2c_master.sv */
// ----------------------------------------------------------
// I2C transaction engine for the NS2009
// one request runs start, address, command write or two byte
// read, then stop, and is answered with xfer_ack
// SCL bit is four divided ticks: low, setup, release, sample
// ----------------------------------------------------------

module rtp_i2c_master #(
    parameter int clk_div = 62                        // clocks per quarter bit
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         xfer_req,    // held until xfer_ack
    input  logic                         xfer_rd,     // 1 = two byte read
    input  logic [7:0]                   xfer_cmd,    // command byte for writes
    output logic                         xfer_ack,
    output logic [rtp_pkg::sample_w-1:0] xfer_sample,
    output logic                         xfer_nack,
    output logic                         scl_drive_low,
    output logic                         sda_drive_low,
    input  logic                         scl_in,
    input  logic                         sda_in
);

    localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_addr,
        st_write,
        st_read_hi,
        st_read_lo,
        st_stop,
        st_done
    } state_e;

    state_e           state;
    logic [1:0]       phase;                          // quarter of the current bit
    logic [3:0]       bit_cnt;                        // 0..7 data, 8 = ack slot
    logic [div_w-1:0] div_cnt;
    logic             busy;
    logic             tick;
    logic             last_bit;
    logic [7:0]       tx_byte;
    rtp_pkg::rx_word_u rx;

    assign busy     = (state != st_idle) && (state != st_done);
    assign tick     = busy && (div_cnt == div_w'(clk_div - 1));
    assign last_bit = (bit_cnt == 4'd8);
    assign tx_byte  = (state == st_addr) ? {rtp_pkg::dev_addr, xfer_rd} : xfer_cmd;

    assign xfer_ack    = (state == st_done);          // held until the request drops
    assign xfer_sample = rx.sample.value;

    // quarter bit divider, parked at zero between transactions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (!busy || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= st_idle;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            scl_drive_low <= 1'b0;                    // bus released
            sda_drive_low <= 1'b0;
            xfer_nack     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    phase   <= 2'd0;
                    bit_cnt <= 4'd0;
                    if (xfer_req && scl_in && sda_in) begin  // only from a free bus
                        xfer_nack <= 1'b0;
                        state     <= st_start;
                    end
                end
                st_done: begin
                    if (!xfer_req) state <= st_idle;  // four phase return
                end
                default: begin
                    if (tick) begin
                        phase <= phase + 2'd1;
                        case (phase)
                            2'd0: begin
                                if (state != st_start) scl_drive_low <= 1'b1;  // scl low
                            end
                            2'd1: begin                              // sda moves, scl low
                                case (state)
                                    st_start:   sda_drive_low <= 1'b1;  // start, scl high
                                    st_addr,
                                    st_write:   sda_drive_low <= last_bit ? 1'b0 :
                                                    ~tx_byte[3'd7 - bit_cnt[2:0]];
                                    st_read_hi: sda_drive_low <= last_bit;  // master ack
                                    st_read_lo: sda_drive_low <= 1'b0;      // master nack
                                    default:    sda_drive_low <= 1'b1;      // stop setup
                                endcase
                            end
                            2'd2: begin
                                scl_drive_low <= 1'b0;           // release scl high
                            end
                            default: begin                       // sample while scl high
                                case (state)
                                    st_start: begin
                                        bit_cnt <= 4'd0;
                                        state   <= st_addr;
                                    end
                                    st_addr,
                                    st_write: begin
                                        if (!last_bit) begin
                                            bit_cnt <= bit_cnt + 4'd1;
                                        end else begin
                                            bit_cnt <= 4'd0;
                                            if (sda_in) begin        // slave nack
                                                xfer_nack <= 1'b1;
                                                state     <= st_stop;
                                            end else if (state == st_write) begin
                                                state <= st_stop;
                                            end else begin
                                                state <= xfer_rd ? st_read_hi : st_write;
                                            end
                                        end
                                    end
                                    st_read_hi,
                                    st_read_lo: begin
                                        if (!last_bit) begin
                                            bit_cnt <= bit_cnt + 4'd1;
                                        end else begin
                                            bit_cnt <= 4'd0;
                                            state   <= (state == st_read_hi) ? st_read_lo :
                                                                              st_stop;
                                        end
                                    end
                                    default: begin               // stop, sda rises
                                        sda_drive_low <= 1'b0;
                                        state         <= st_done;
                                    end
                                endcase
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // receive shifter, msb first through the byte view
    always_ff @(posedge clk) begin
        if (tick && (phase == 2'd3) && !last_bit) begin
            if (state == st_read_hi) begin
                rx.bytes.hi <= {rx.bytes.hi[6:0], sda_in};
            end else if (state == st_read_lo) begin
                rx.bytes.lo <= {rx.bytes.lo[6:0], sda_in};
            end
        end
    end

endmodule

/* source/rtp_pkg.sv */
// ----------------------------------------------------------
// shared constants and types for the NS2009 touch scan core
// device address, conversion commands and sample format
// referenced by scoped names from the RTL blocks
// ----------------------------------------------------------

package rtp_pkg;

    localparam logic [6:0] dev_addr    = 7'h48;  // 0x90 write, 0x91 read on the wire

    localparam logic [7:0] cmd_read_x  = 8'hC0;  // x position conversion
    localparam logic [7:0] cmd_read_y  = 8'hD0;  // y position conversion
    localparam logic [7:0] cmd_read_z1 = 8'hE0;  // z1 pressure conversion

    localparam int sample_w = 12;                // converter resolution

    // two received bytes, seen as raw bytes or as a left aligned sample
    typedef union packed {
        struct packed {
            logic [7:0] hi;                      // first byte on the bus
            logic [7:0] lo;                      // second byte on the bus
        } bytes;
        struct packed {
            logic [sample_w-1:0] value;          // msb first result
            logic [3:0]          pad;            // trailing zeros from the device
        } sample;
    } rx_word_u;

    typedef enum logic [1:0] {
        axis_x  = 2'd0,
        axis_y  = 2'd1,
        axis_z1 = 2'd2
    } axis_e;

endpackage
